//--- logic/user_config.svh
// Build-time sizes and analyzer field positions of the counter peripheral
// Include in any file that sizes a port or picks analyzer probes
`ifndef USER_CONFIG_SVH
`define USER_CONFIG_SVH

// Width of one counter
`define USER_CNT_BITS 16

// Counters in the bank
`define USER_NUM_CNT 4

// Word address of the enable register, after the counter words
`define USER_ENABLE_WORD 4

// Lowest probe of the two-bit counter select
`define USER_LA_SEL_LSB 36

// Lowest enable bit of the load mask, one bit per counter bit
`define USER_LA_MASK_LSB 16

`endif

//--- logic/wb_pkg.sv
// Register-bus types shared by the Wishbone port, the arbiter and the counter bank
// Referenced by scoped name, e.g. wb_pkg::reg_req_t
package wb_pkg;

    // One register access, held as a level until granted
    // A read carries an all-zero strobe
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [3:0]  strb;
        // Word index, byte address bits [4:2]
        logic [2:0]  addr;
        logic [31:0] wdata;
    } reg_req_t;

    // Reply to one access
    // valid is a single-cycle pulse, one cycle after the access
    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } reg_rsp_t;

endpackage

//--- logic/counter_pkg.sv
// Counter-side types: analyzer load fields, the count vector and the requester id
// Referenced by scoped name, e.g. counter_pkg::cnt_vec_t
`include "user_config.svh"

package counter_pkg;

    // Analyzer load as sampled from the probes
    typedef struct packed {
        // High while any mask bit is enabled
        logic                               valid;
        logic [$clog2(`USER_NUM_CNT)-1:0]   sel;
        // Bits of the counter that take the value
        logic [`USER_CNT_BITS-1:0]          mask;
        logic [`USER_CNT_BITS-1:0]          value;
    } la_load_t;

    // All counters, counter 0 in the low slice
    typedef logic [`USER_NUM_CNT-1:0][`USER_CNT_BITS-1:0] cnt_vec_t;

    // Who owns the access in flight
    typedef enum logic {
        SRC_WB = 1'b0,
        SRC_LA = 1'b1
    } req_src_e;

endpackage

//--- logic/wb_slave_port.sv
// Wishbone slave front end; issues one register-bus request per bus cycle
// Ack and read data come straight from the routed bank response
module wb_slave_port (
    input  logic               clk,
    input  logic               reset,
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  logic [3:0]         wb_sel_i,
    input  logic [31:0]        wb_adr_i,
    input  logic [31:0]        wb_dat_i,
    output logic               wb_ack_o,
    output logic [31:0]        wb_dat_o,
    output wb_pkg::reg_req_t   req_o,
    input  wb_pkg::reg_rsp_t   rsp_i
);

    wb_pkg::reg_req_t req_q;
    // Set from request until the edge after the ack
    logic             busy_q;
    logic             start;

    // New cycle seen only while idle, so a held strobe is taken once
    assign start = wb_cyc_i && wb_stb_i && !busy_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q      <= 1'b0;
            req_q.valid <= 1'b0;
        end else begin
            // Wishbone always wins arbitration, so the request lasts one cycle
            req_q.valid <= start;
            if (start) begin
                busy_q <= 1'b1;
            end else if (rsp_i.valid) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Payload fields, captured with the request
    always_ff @(posedge clk) begin
        if (start) begin
            req_q.write <= wb_we_i;
            // Reads carry no strobe
            req_q.strb  <= wb_we_i ? wb_sel_i : 4'b0000;
            // Byte address to word index
            req_q.addr  <= wb_adr_i[4:2];
            req_q.wdata <= wb_dat_i;
        end
    end

    assign req_o = req_q;

    // Ack is the response pulse
    assign wb_ack_o = rsp_i.valid;
    assign wb_dat_o = rsp_i.rdata;

    // The master must still hold the cycle when the ack returns
    ack_in_cycle: assert property (
        @(posedge clk) disable iff (reset)
        wb_ack_o |-> (wb_cyc_i && wb_stb_i)
    ) else $error("wb ack outside an active cycle");

endmodule

//--- logic/la_load_port.sv
// Logic-analyzer load front end; probe levels become masked counter loads
// The request is re-sampled every cycle, so a lost arbitration just repeats
`include "user_config.svh"

module la_load_port (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [63:0]                la_data_i,
    input  logic [63:0]                la_oenb_i,
    output wb_pkg::reg_req_t           req_o,
    output logic [`USER_CNT_BITS-1:0]  mask_o
);

    localparam int SEL_W = $clog2(`USER_NUM_CNT);

    counter_pkg::la_load_t load_d;
    counter_pkg::la_load_t load_q;

    // Enable bits are active low, inverted into a load mask
    always_comb begin
        load_d.mask  = ~la_oenb_i[`USER_LA_MASK_LSB +: `USER_CNT_BITS];
        load_d.sel   = la_data_i[`USER_LA_SEL_LSB +: SEL_W];
        load_d.value = la_data_i[`USER_CNT_BITS-1:0];
        // Any enabled mask bit asks for a load
        load_d.valid = |load_d.mask;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            load_q.valid <= 1'b0;
        end else begin
            load_q <= load_d;
        end
    end

    // Loads always write, whole word strobed; the mask picks the bits
    always_comb begin
        req_o.valid = load_q.valid;
        req_o.write = 1'b1;
        req_o.strb  = 4'b1111;
        // Only counter words are reachable from the analyzer
        req_o.addr  = {{(3 - SEL_W){1'b0}}, load_q.sel};
        req_o.wdata = {{(32 - `USER_CNT_BITS){1'b0}}, load_q.value};
    end

    assign mask_o = load_q.mask;

endmodule

//--- logic/reg_arbiter.sv
// Fixed-priority arbiter in front of the counter bank, Wishbone over analyzer
// Remembers the winner so the bank response goes back to it
`include "user_config.svh"

module reg_arbiter (
    input  logic                       clk,
    input  logic                       reset,
    input  wb_pkg::reg_req_t           wb_req_i,
    input  wb_pkg::reg_req_t           la_req_i,
    input  logic [`USER_CNT_BITS-1:0]  la_mask_i,
    output wb_pkg::reg_req_t           bank_req_o,
    output logic [`USER_CNT_BITS-1:0]  bank_mask_o,
    input  wb_pkg::reg_rsp_t           bank_rsp_i,
    output wb_pkg::reg_rsp_t           wb_rsp_o,
    output wb_pkg::reg_rsp_t           la_rsp_o
);

    counter_pkg::req_src_e grant_src;
    counter_pkg::req_src_e src_q;
    // A granted access whose response is due this cycle
    logic                  pending_q;

    // Wishbone wins whenever it asks
    assign grant_src = wb_req_i.valid ? counter_pkg::SRC_WB : counter_pkg::SRC_LA;

    // Wishbone writes use every bit of the strobed bytes
    always_comb begin
        if (grant_src == counter_pkg::SRC_WB) begin
            bank_req_o  = wb_req_i;
            bank_mask_o = '1;
        end else begin
            bank_req_o  = la_req_i;
            bank_mask_o = la_mask_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q <= 1'b0;
            src_q     <= counter_pkg::SRC_WB;
        end else begin
            pending_q <= bank_req_o.valid;
            if (bank_req_o.valid) begin
                src_q <= grant_src;
            end
        end
    end

    // Route the reply; read data is shared, valid goes to the owner only
    always_comb begin
        wb_rsp_o       = bank_rsp_i;
        la_rsp_o       = bank_rsp_i;
        wb_rsp_o.valid = bank_rsp_i.valid && pending_q && (src_q == counter_pkg::SRC_WB);
        la_rsp_o.valid = bank_rsp_i.valid && pending_q && (src_q == counter_pkg::SRC_LA);
    end

    // Every grant gets its reply next cycle, at Wishbone only if Wishbone asked
    grant_reply: assert property (
        @(posedge clk) disable iff (reset)
        bank_req_o.valid |=> (bank_rsp_i.valid && wb_rsp_o.valid == $past(wb_req_i.valid))
    ) else $error("bank reply missing or routed to the wrong source");

endmodule

//--- logic/counter_bank.sv
// Bank of free-running counters with enable register and wrap interrupts
// Served by a single register-bus port, reply one cycle after the access
`include "user_config.svh"

module counter_bank (
    input  logic                       clk,
    input  logic                       reset,
    input  wb_pkg::reg_req_t           req_i,
    input  logic [`USER_CNT_BITS-1:0]  mask_i,
    output wb_pkg::reg_rsp_t           rsp_o,
    output counter_pkg::cnt_vec_t      count_o,
    output logic [2:0]                 irq_o
);

    localparam int NUM_CNT  = `USER_NUM_CNT;
    localparam int CNT_BITS = `USER_CNT_BITS;
    localparam int NUM_IRQ  = 3;

    counter_pkg::cnt_vec_t  cnt_q;
    logic [NUM_CNT-1:0]     en_q;
    logic [NUM_IRQ-1:0]     irq_q;
    wb_pkg::reg_rsp_t       rsp_q;

    logic [CNT_BITS-1:0]    bit_mask;
    logic [NUM_CNT-1:0]     wr_sel;
    logic [NUM_CNT-1:0]     inc;
    logic [NUM_CNT-1:0]     wrap;
    logic                   en_wr;
    logic [31:0]            rd_data;

    // Strobed bytes of the access, one flag per counter bit
    always_comb begin
        for (int b = 0; b < CNT_BITS / 8; b++) begin
            bit_mask[b*8 +: 8] = {8{req_i.strb[b]}};
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_CNT; k++) begin
            // A written counter skips its increment that cycle
            wr_sel[k] = req_i.valid && req_i.write && (req_i.addr == k);
            inc[k]    = en_q[k] && !wr_sel[k];
            wrap[k]   = inc[k] && (cnt_q[k] == '1);
        end
        en_wr = req_i.valid && req_i.write && (req_i.addr == `USER_ENABLE_WORD);
    end

    // Read value is the state before this access
    always_comb begin
        rd_data = '0;
        if (req_i.addr < NUM_CNT) begin
            rd_data[CNT_BITS-1:0] = cnt_q[req_i.addr[$clog2(NUM_CNT)-1:0]];
        end else if (req_i.addr == `USER_ENABLE_WORD) begin
            rd_data[NUM_CNT-1:0] = en_q;
        end
        // Remaining words read as zero
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt_q       <= '0;
            en_q        <= '1;
            irq_q       <= '0;
            rsp_q.valid <= 1'b0;
        end else begin
            for (int k = 0; k < NUM_CNT; k++) begin
                if (wr_sel[k]) begin
                    // Unmasked bits of a full-strobe load end up cleared
                    cnt_q[k] <= (cnt_q[k] & ~bit_mask)
                              | (req_i.wdata[CNT_BITS-1:0] & bit_mask & mask_i);
                end else if (inc[k]) begin
                    cnt_q[k] <= cnt_q[k] + 1'b1;
                end
            end
            // Enable bits live in byte 0
            if (en_wr && req_i.strb[0]) begin
                en_q <= req_i.wdata[NUM_CNT-1:0];
            end
            // Pulse in the cycle after the wrap
            irq_q       <= wrap[NUM_IRQ-1:0];
            rsp_q.valid <= req_i.valid;
        end
    end

    // Read data payload
    always_ff @(posedge clk) begin
        rsp_q.rdata <= rd_data;
    end

    assign rsp_o   = rsp_q;
    assign count_o = cnt_q;
    assign irq_o   = irq_q;

    // Only a full-strobe access may narrow the written bits by mask
    masked_load_full_strobe: assert property (
        @(posedge clk) disable iff (reset)
        (req_i.valid && req_i.write && mask_i != '1) |-> (req_i.strb == 4'b1111)
    ) else $error("masked load without a full strobe");

endmodule

//--- logic/user_proj_top.sv
// User-area top of the counter peripheral
// Wires the Wishbone and analyzer ports through the arbiter to the counter bank
`include "user_config.svh"

module user_proj_top (
    input  logic                       clk,
    input  logic                       reset,
    // Wishbone slave
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    input  logic                       wb_we_i,
    input  logic [3:0]                 wb_sel_i,
    input  logic [31:0]                wb_adr_i,
    input  logic [31:0]                wb_dat_i,
    output logic                       wb_ack_o,
    output logic [31:0]                wb_dat_o,
    // Logic analyzer
    input  logic [63:0]                la_data_i,
    input  logic [63:0]                la_oenb_i,
    output logic [63:0]                la_data_o,
    // GPIO, output only
    output logic [`USER_CNT_BITS-1:0]  io_out_o,
    output logic [`USER_CNT_BITS-1:0]  io_oeb_o,
    output logic [2:0]                 irq_o
);

    wb_pkg::reg_req_t           wb_req;
    wb_pkg::reg_rsp_t           wb_rsp;
    wb_pkg::reg_req_t           la_req;
    logic [`USER_CNT_BITS-1:0]  la_mask;
    wb_pkg::reg_req_t           bank_req;
    logic [`USER_CNT_BITS-1:0]  bank_mask;
    wb_pkg::reg_rsp_t           bank_rsp;
    counter_pkg::cnt_vec_t      count;

    wb_slave_port i_wb_port (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_sel_i (wb_sel_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_ack_o (wb_ack_o),
        .wb_dat_o (wb_dat_o),
        .req_o    (wb_req),
        .rsp_i    (wb_rsp)
    );

    la_load_port i_la_port (
        .clk       (clk),
        .reset     (reset),
        .la_data_i (la_data_i),
        .la_oenb_i (la_oenb_i),
        .req_o     (la_req),
        .mask_o    (la_mask)
    );

    // Analyzer loads need no reply, so la_rsp_o stays open
    reg_arbiter i_arbiter (
        .clk         (clk),
        .reset       (reset),
        .wb_req_i    (wb_req),
        .la_req_i    (la_req),
        .la_mask_i   (la_mask),
        .bank_req_o  (bank_req),
        .bank_mask_o (bank_mask),
        .bank_rsp_i  (bank_rsp),
        .wb_rsp_o    (wb_rsp),
        .la_rsp_o    ()
    );

    counter_bank i_bank (
        .clk     (clk),
        .reset   (reset),
        .req_i   (bank_req),
        .mask_i  (bank_mask),
        .rsp_o   (bank_rsp),
        .count_o (count),
        .irq_o   (irq_o)
    );

    // Counter 0 on the pads, all counters on the analyzer
    assign io_out_o  = count[0];
    assign la_data_o = count;
    // Pads stay tristated while in reset
    assign io_oeb_o  = {`USER_CNT_BITS{reset}};

endmodule

//--- sim/tb_user_proj.sv
// Self-checking testbench for the counter peripheral top level
// Random Wishbone and analyzer traffic from a fixed seed, compared with a cycle model
`include "user_config.svh"

module tb_user_proj;

    // Tests need well under 1000 cycles, limit leaves a wide margin
    localparam int CYCLE_LIMIT = 4000;
    localparam int ACK_WAIT    = 8;

    // One access as the bank sees it in the model
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [2:0]  word;
        logic [3:0]  strb;
        logic [15:0] bits;
        logic [31:0] data;
    } access_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_sel;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic        wb_ack;
    logic [31:0] wb_dat_r;
    logic [63:0] la_data_in;
    logic [63:0] la_oenb;
    logic [63:0] la_data_out;
    logic [15:0] io_out;
    logic [15:0] io_oeb;
    logic [2:0]  irq;

    // Model state
    counter_pkg::cnt_vec_t mdl_cnt;
    logic [3:0]            mdl_en;
    logic [2:0]            mdl_irq;
    logic                  exp_ack;
    logic [31:0]           exp_rd;
    access_t               wb_acc;
    access_t               la_pend;

    logic [31:0] rng_state;
    int          cycle_count;
    string       test_name;

    user_proj_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .wb_cyc_i  (wb_cyc),
        .wb_stb_i  (wb_stb),
        .wb_we_i   (wb_we),
        .wb_sel_i  (wb_sel),
        .wb_adr_i  (wb_adr),
        .wb_dat_i  (wb_dat_w),
        .wb_ack_o  (wb_ack),
        .wb_dat_o  (wb_dat_r),
        .la_data_i (la_data_in),
        .la_oenb_i (la_oenb),
        .la_data_o (la_data_out),
        .io_out_o  (io_out),
        .io_oeb_o  (io_oeb),
        .irq_o     (irq)
    );

    always #20 clk = ~clk;

    // 32-bit xorshift
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] model_read(input logic [2:0] word);
        if (word < `USER_NUM_CNT) begin
            return {16'h0000, mdl_cnt[word[1:0]]};
        end else if (word == `USER_ENABLE_WORD) begin
            return {28'h0, mdl_en};
        end
        return 32'h0;
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("ERR %s %s expected %0h actual %0h", test_name, what, expected, actual);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_failure(input string what);
        $display("%s: %s", test_name, what);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic wait_cycle();
        @(posedge clk);
        #2;
    endtask

    // Model advances on each rising edge, by the bank rules
    always @(posedge clk) begin : model_step
        access_t    act;
        logic [3:0] wrap_now;
        logic       written;
        logic       from_la;
        if (reset) begin
            mdl_cnt = '0;
            mdl_en  = 4'hF;
            mdl_irq = 3'b000;
            exp_ack = 1'b0;
            la_pend = '0;
        end else begin
            // Wishbone owns the bank whenever it asks
            act     = wb_acc.valid ? wb_acc : la_pend;
            from_la = !wb_acc.valid;
            exp_ack = wb_acc.valid;
            if (wb_acc.valid) begin
                exp_rd = model_read(wb_acc.word);
            end
            for (int k = 0; k < `USER_NUM_CNT; k++) begin
                written     = act.valid && act.write && (act.word == k);
                wrap_now[k] = mdl_en[k] && !written && (mdl_cnt[k] == 16'hFFFF);
                if (written && from_la) begin
                    // A load keeps only the masked bits of the value
                    mdl_cnt[k] = act.data[15:0] & act.bits;
                end else if (written) begin
                    // Strobed bytes take the bus data
                    mdl_cnt[k] = (mdl_cnt[k] & ~act.bits) | (act.data[15:0] & act.bits);
                end else if (mdl_en[k]) begin
                    mdl_cnt[k] = mdl_cnt[k] + 16'd1;
                end
            end
            if (act.valid && act.write && act.word == `USER_ENABLE_WORD && act.strb[0]) begin
                mdl_en = act.data[3:0];
            end
            mdl_irq = wrap_now[2:0];
            // Probe levels sampled here reach the bank one edge later
            la_pend.bits  = ~la_oenb[`USER_LA_MASK_LSB +: 16];
            la_pend.valid = |la_pend.bits;
            la_pend.write = 1'b1;
            la_pend.word  = {1'b0, la_data_in[`USER_LA_SEL_LSB +: 2]};
            la_pend.strb  = 4'hF;
            la_pend.data  = {16'h0000, la_data_in[15:0]};
        end
    end

    // Outputs compared at the falling edge, away from any update
    always @(negedge clk) begin
        if (reset) begin
            assert (io_oeb == 16'hFFFF) else report_mismatch("io_oeb in reset", 16'hFFFF, io_oeb);
        end else begin
            assert (la_data_out == mdl_cnt) else report_mismatch("la_data_o", mdl_cnt, la_data_out);
            assert (io_out == mdl_cnt[0]) else report_mismatch("io_out_o", mdl_cnt[0], io_out);
            assert (irq == mdl_irq) else report_mismatch("irq_o", mdl_irq, irq);
            assert (wb_ack == exp_ack) else report_mismatch("wb_ack_o", exp_ack, wb_ack);
            assert (io_oeb == 16'h0000) else report_mismatch("io_oeb_o", 16'h0000, io_oeb);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    // One Wishbone cycle, entered and left 2 time units after a rising edge
    task automatic wb_access(input logic we, input logic [2:0] word, input logic [3:0] sel,
                             input logic [31:0] data, output logic [31:0] rdata);
        int edges;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_sel   = sel;
        wb_adr   = {27'h0, word, 2'b00};
        wb_dat_w = data;
        wait_cycle();
        edges = 1;
        // Port holds the request now, the bank serves it at the next edge
        wb_acc.valid = 1'b1;
        wb_acc.write = we;
        wb_acc.word  = word;
        wb_acc.strb  = we ? sel : 4'h0;
        wb_acc.bits  = {{8{sel[1]}}, {8{sel[0]}}};
        wb_acc.data  = data;
        wait_cycle();
        edges++;
        wb_acc.valid = 1'b0;
        while (!wb_ack && edges < ACK_WAIT) begin
            wait_cycle();
            edges++;
        end
        assert (wb_ack) else report_failure("Wishbone cycle never got an ack");
        assert (edges == 2) else report_mismatch("ack latency", 2, edges);
        rdata = wb_dat_r;
        // Master registers the ack at the next edge, then ends the cycle
        wait_cycle();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // Present an analyzer load for a number of cycles, then release the probes
    task automatic drive_la(input logic [1:0] sel, input logic [15:0] mask,
                            input logic [15:0] value, input int hold);
        la_data_in = 64'h0;
        la_data_in[`USER_LA_SEL_LSB +: 2] = sel;
        la_data_in[15:0] = value;
        la_oenb = '1;
        la_oenb[`USER_LA_MASK_LSB +: 16] = ~mask;
        repeat (hold) wait_cycle();
        la_oenb = '1;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] rdata;
        logic [63:0] snap;
        logic [15:0] mask;
        logic [15:0] step;
        logic [15:0] want;
        logic [3:0]  en_pat;
        int          idx;
        int          n;
        rng_state   = 32'd86;
        cycle_count = 0;
        reset       = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_sel      = 4'h0;
        wb_adr      = 32'h0;
        wb_dat_w    = 32'h0;
        la_data_in  = 64'h0;
        la_oenb     = '1;
        wb_acc      = '0;
        test_name   = "reset";
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        // Free counting after reset
        test_name = "count_up";
        repeat (8) wait_cycle();
        snap = mdl_cnt;
        wait_cycle();
        for (int k = 0; k < 4; k++) begin
            want = snap[k*16 +: 16] + 16'd1;
            assert (la_data_out[k*16 +: 16] == want)
            else report_mismatch("counter step", want, la_data_out[k*16 +: 16]);
        end
        want = snap[15:0] + 16'd1;
        assert (io_out == want) else report_mismatch("io_out_o", want, io_out);

        // Byte-strobed writes, enable word kept out
        test_name = "wb_write";
        for (int i = 0; i < 32; i++) begin
            r  = next_rand();
            r2 = next_rand();
            if (r[2:0] == 3'd4) r[2:0] = 3'd0;
            wb_access(1'b1, r[2:0], r[7:4], r2, rdata);
        end

        test_name = "wb_read";
        for (int i = 0; i < 32; i++) begin
            r = next_rand();
            wb_access(1'b0, r[2:0], r[7:4], 32'h0, rdata);
            assert (rdata == exp_rd) else report_mismatch("read data", exp_rd, rdata);
        end
        for (int w = 4; w < 8; w++) begin
            wb_access(1'b0, w[2:0], 4'hF, 32'h0, rdata);
            assert (rdata == exp_rd) else report_mismatch("read data", exp_rd, rdata);
        end

        // At least one counter frozen
        test_name = "enable";
        r      = next_rand();
        en_pat = (r[3:0] == 4'hF) ? 4'hA : r[3:0];
        wb_access(1'b1, `USER_ENABLE_WORD, 4'b0001, {28'h0, en_pat}, rdata);
        snap = mdl_cnt;
        repeat (6) wait_cycle();
        for (int k = 0; k < 4; k++) begin
            step = en_pat[k] ? 16'd6 : 16'd0;
            want = snap[k*16 +: 16] + step;
            assert (la_data_out[k*16 +: 16] == want)
            else report_mismatch("frozen or running", want, la_data_out[k*16 +: 16]);
        end
        wb_access(1'b1, `USER_ENABLE_WORD, 4'b0001, 32'hF, rdata);
        repeat (3) wait_cycle();

        // Masked analyzer loads, bus idle
        test_name = "la_load";
        for (int i = 0; i < 12; i++) begin
            r    = next_rand();
            r2   = next_rand();
            mask = (r[15:0] == 16'h0) ? 16'h0001 : r[15:0];
            idx  = r2[1:0];
            drive_la(r2[1:0], mask, r[31:16], 1);
            wait_cycle();
            assert (la_data_out[idx*16 +: 16] == (mask & r[31:16]))
            else report_mismatch("loaded value", mask & r[31:16], la_data_out[idx*16 +: 16]);
            wait_cycle();
        end

        // Load held across a Wishbone write, applied once the bus is idle
        test_name = "la_vs_wb";
        for (int i = 0; i < 6; i++) begin
            r    = next_rand();
            r2   = next_rand();
            snap = {next_rand(), 32'h0};
            mask = (r[15:0] == 16'h0) ? 16'h8000 : r[15:0];
            idx  = r2[1:0];
            fork
                wb_access(1'b1, {1'b0, r2[3:2]}, 4'b0011, snap[63:32], rdata);
                drive_la(r2[1:0], mask, r[31:16], 2);
            join
            // Load lands at the edge that ends the bus cycle
            assert (la_data_out[idx*16 +: 16] == (mask & r[31:16]))
            else report_mismatch("delayed load", mask & r[31:16], la_data_out[idx*16 +: 16]);
        end

        // Counter 1 two steps from wrapping
        test_name = "wrap_irq";
        wb_access(1'b1, 3'd1, 4'b0011, 32'h0000FFFE, rdata);
        n = 0;
        while (!irq[1] && n < 8) begin
            wait_cycle();
            n++;
        end
        assert (irq[1]) else report_failure("irq_o[1] never pulsed after counter 1 wrapped");
        wait_cycle();
        assert (!irq[1]) else report_mismatch("irq_o[1] pulse width", 0, irq[1]);

        repeat (4) wait_cycle();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+logic
logic/wb_pkg.sv
logic/counter_pkg.sv
logic/wb_slave_port.sv
logic/la_load_port.sv
logic/reg_arbiter.sv
logic/counter_bank.sv
logic/user_proj_top.sv
sim/tb_user_proj.sv
